// ==== Makefile ====
TOP = tb_e_exec

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f la_exec.f
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

// ==== la_exec.f ====
+incdir+source
source/la_exec_pkg.sv
source/e_exec_if.sv
source/e_alu.sv
source/e_regfile.sv
source/e_decode.sv
source/e_exec_top.sv
tb/e_exec_checker.sv
tb/tb_e_exec.sv

// ==== source/e_alu.sv ====
`timescale 1ns/1ps
`include "e_alu_defines.svh"

module e_alu (
  e_exec_if.alu exec
);

  logic [31:0] bw_result;    // Bitwise ops
  logic [31:0] li_result;    // Load immediate
  logic [31:0] int_result;   // Add, sub, compares
  logic [31:0] sft_result;   // Shifts
  logic [31:0] li_imm;
  logic [4:0]  shamt;

  assign li_imm = {exec.r0[19:0], 12'b0};
  assign shamt  = exec.r0[4:0];

  always_comb begin
    case (exec.grand_op)
      `GRAND_OP_BW: begin
        exec.result = bw_result;
      end
      `GRAND_OP_LI: begin
        exec.result = li_result;
      end
      `GRAND_OP_INT: begin
        exec.result = int_result;
      end
      `GRAND_OP_SFT: begin
        exec.result = sft_result;
      end
      default: begin
        exec.result = 32'b0;
      end
    endcase
  end

  always_comb begin
    case (exec.op)
      `BW_AND: begin
        bw_result = exec.r1 & exec.r0;
      end
      `BW_OR: begin
        bw_result = exec.r1 | exec.r0;
      end
      `BW_NOR: begin
        bw_result = ~(exec.r1 | exec.r0);
      end
      `BW_XOR: begin
        bw_result = exec.r1 ^ exec.r0;
      end
      `BW_ANDN: begin
        bw_result = exec.r1 & ~exec.r0;
      end
      `BW_ORN: begin
        bw_result = exec.r1 | ~exec.r0;
      end
      default: begin
        bw_result = 32'b0;
      end
    endcase
  end

  always_comb begin
    case (exec.op)
      `LI_LUI:     li_result = li_imm;
      `LI_PCADDUI: li_result = li_imm + exec.pc;
      default:     li_result = 32'b0;
    endcase
  end

  always_comb begin
    case (exec.op)
      `INT_ADD: begin
        int_result = exec.r1 + exec.r0;
      end
      `INT_SUB: begin
        int_result = exec.r1 - exec.r0;
      end
      `INT_SLT: begin
        int_result = {31'b0, $signed(exec.r1) < $signed(exec.r0)};
      end
      `INT_SLTU: begin
        int_result = {31'b0, exec.r1 < exec.r0};
      end
      default: begin
        int_result = 32'b0;
      end
    endcase
  end

  // Only the low 5 bits of rk count
  always_comb begin
    case (exec.op)
      `SFT_SLL: sft_result = exec.r1 << shamt;
      `SFT_SRL: sft_result = exec.r1 >> shamt;
      `SFT_SRA: sft_result = $unsigned($signed(exec.r1) >>> shamt);
      default:  sft_result = 32'b0;
    endcase
  end

endmodule

// ==== source/e_alu_defines.svh ====
`ifndef E_ALU_DEFINES_SVH
`define E_ALU_DEFINES_SVH

// Group codes, zero left free for no operation
`define GRAND_OP_BW  3'd1
`define GRAND_OP_LI  3'd2
`define GRAND_OP_INT 3'd3
`define GRAND_OP_SFT 3'd4

`define BW_AND  3'd0
`define BW_OR   3'd1
`define BW_NOR  3'd2
`define BW_XOR  3'd3
`define BW_ANDN 3'd4
`define BW_ORN  3'd5

`define LI_LUI     3'd0
`define LI_PCADDUI 3'd1

`define INT_ADD  3'd0
`define INT_SUB  3'd1
`define INT_SLT  3'd2
`define INT_SLTU 3'd3

`define SFT_SLL 3'd0
`define SFT_SRL 3'd1
`define SFT_SRA 3'd2

`endif

// ==== source/e_decode.sv ====
`timescale 1ns/1ps
`include "e_alu_defines.svh"

module e_decode
  import la_exec_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        inst_valid_i,
  input  inst_u       inst_i,
  input  logic [31:0] pc_i,
  output reg_idx_t    rj_addr_o,
  output reg_idx_t    rk_addr_o,
  input  logic [31:0] rj_data_i,
  input  logic [31:0] rk_data_i,
  e_exec_if.ctrl      alu,
  output logic        wb_we_o,
  output logic        wb_valid_o,
  output reg_idx_t    wb_rd_o,
  output logic [31:0] wb_data_o,
  output logic        illegal_o
);

  logic legal;

  assign rj_addr_o = inst_i.r3.rj;
  assign rk_addr_o = inst_i.r3.rk;

  always_comb begin
    alu.r1       = rj_data_i;
    alu.r0       = rk_data_i;
    alu.pc       = pc_i;
    alu.grand_op = 3'd0;
    alu.op       = 3'd0;
    legal        = 1'b1;
    case (inst_i.r3.opcode)
      OPC_ADD:  begin alu.grand_op = `GRAND_OP_INT; alu.op = `INT_ADD;  end
      OPC_SUB:  begin alu.grand_op = `GRAND_OP_INT; alu.op = `INT_SUB;  end
      OPC_SLT:  begin alu.grand_op = `GRAND_OP_INT; alu.op = `INT_SLT;  end
      OPC_SLTU: begin alu.grand_op = `GRAND_OP_INT; alu.op = `INT_SLTU; end
      OPC_NOR:  begin alu.grand_op = `GRAND_OP_BW;  alu.op = `BW_NOR;   end
      OPC_AND:  begin alu.grand_op = `GRAND_OP_BW;  alu.op = `BW_AND;   end
      OPC_OR:   begin alu.grand_op = `GRAND_OP_BW;  alu.op = `BW_OR;    end
      OPC_XOR:  begin alu.grand_op = `GRAND_OP_BW;  alu.op = `BW_XOR;   end
      OPC_ORN:  begin alu.grand_op = `GRAND_OP_BW;  alu.op = `BW_ORN;   end
      OPC_ANDN: begin alu.grand_op = `GRAND_OP_BW;  alu.op = `BW_ANDN;  end
      OPC_SLL:  begin alu.grand_op = `GRAND_OP_SFT; alu.op = `SFT_SLL;  end
      OPC_SRL:  begin alu.grand_op = `GRAND_OP_SFT; alu.op = `SFT_SRL;  end
      OPC_SRA:  begin alu.grand_op = `GRAND_OP_SFT; alu.op = `SFT_SRA;  end
      default: begin
        // Not a 3R form, try the 20-bit immediate view
        alu.r0       = {12'b0, inst_i.ri20.si20};
        alu.grand_op = `GRAND_OP_LI;
        if (inst_i.ri20.opcode == OPC_LU12I) begin
          alu.op = `LI_LUI;
        end else if (inst_i.ri20.opcode == OPC_PCADDU12I) begin
          alu.op = `LI_PCADDUI;
        end else begin
          alu.grand_op = 3'd0;
          legal        = 1'b0;
        end
      end
    endcase
  end

  // One cycle writeback stage
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o <= 1'b0;
      illegal_o  <= 1'b0;
      wb_rd_o    <= '0;
      wb_data_o  <= '0;
    end else begin
      wb_valid_o <= inst_valid_i & legal;
      illegal_o  <= inst_valid_i & ~legal;
      if (inst_valid_i && legal) begin
        wb_rd_o   <= inst_i.r3.rd;   // rd sits in the same bits for both forms
        wb_data_o <= alu.result;
      end
    end
  end

  assign wb_we_o = wb_valid_o;

endmodule

// ==== source/e_exec_if.sv ====
`timescale 1ns/1ps

interface e_exec_if;

  logic [31:0] r1;        // rj value
  logic [31:0] r0;        // rk value or si20
  logic [31:0] pc;
  logic [2:0]  grand_op;
  logic [2:0]  op;
  logic [31:0] result;

  modport ctrl (
    output r1,
    output r0,
    output pc,
    output grand_op,
    output op,
    input  result
  );

  modport alu (
    input  r1,
    input  r0,
    input  pc,
    input  grand_op,
    input  op,
    output result
  );

endinterface

// ==== source/e_exec_top.sv ====
`timescale 1ns/1ps

module e_exec_top
  import la_exec_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        inst_valid_i,
  input  logic [31:0] inst_i,
  input  logic [31:0] pc_i,
  output logic        wb_valid_o,
  output reg_idx_t    wb_rd_o,
  output logic [31:0] wb_data_o,
  output logic        illegal_o
);

  reg_idx_t    rj_addr;
  reg_idx_t    rk_addr;
  logic [31:0] rj_data;
  logic [31:0] rk_data;
  logic        wb_we;

  e_exec_if ex_if ();

  e_decode u_decode (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .rj_addr_o    (rj_addr),
    .rk_addr_o    (rk_addr),
    .rj_data_i    (rj_data),
    .rk_data_i    (rk_data),
    .alu          (ex_if.ctrl),
    .wb_we_o      (wb_we),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o),
    .illegal_o    (illegal_o)
  );

  // Writeback port fed straight from the wb registers
  e_regfile u_regfile (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rj_addr_i (rj_addr),
    .rk_addr_i (rk_addr),
    .rj_data_o (rj_data),
    .rk_data_o (rk_data),
    .we_i      (wb_we),
    .wd_addr_i (wb_rd_o),
    .wd_data_i (wb_data_o)
  );

  e_alu u_alu (
    .exec (ex_if.alu)
  );

endmodule

// ==== source/e_regfile.sv ====
`timescale 1ns/1ps

module e_regfile
  import la_exec_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  reg_idx_t    rj_addr_i,
  input  reg_idx_t    rk_addr_i,
  output logic [31:0] rj_data_o,
  output logic [31:0] rk_data_o,
  input  logic        we_i,
  input  reg_idx_t    wd_addr_i,
  input  logic [31:0] wd_data_i
);

  logic [31:0] regs [1:31];   // r0 is hardwired

  // Read with write-through bypass
  function automatic logic [31:0] read_port(input reg_idx_t addr);
    if (addr == '0) begin
      return 32'b0;
    end else if (we_i && wd_addr_i == addr) begin
      return wd_data_i;
    end else begin
      return regs[addr];
    end
  endfunction

  always_comb begin
    rj_data_o = read_port(rj_addr_i);
    rk_data_o = read_port(rk_addr_i);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wd_addr_i != '0) begin
      regs[wd_addr_i] <= wd_data_i;
    end
  end

endmodule

// ==== source/la_exec_pkg.sv ====
package la_exec_pkg;

  typedef logic [4:0] reg_idx_t;

  // Register-register format
  typedef struct packed {
    logic [16:0] opcode;
    reg_idx_t    rk;
    reg_idx_t    rj;
    reg_idx_t    rd;
  } inst_r3_t;

  // 20-bit immediate format
  typedef struct packed {
    logic [6:0]  opcode;
    logic [19:0] si20;
    reg_idx_t    rd;
  } inst_ri20_t;

  // Same word, two decodings
  typedef union packed {
    inst_r3_t   r3;
    inst_ri20_t ri20;
  } inst_u;

  localparam logic [16:0] OPC_ADD  = 17'h00020;
  localparam logic [16:0] OPC_SUB  = 17'h00022;
  localparam logic [16:0] OPC_SLT  = 17'h00024;
  localparam logic [16:0] OPC_SLTU = 17'h00025;
  localparam logic [16:0] OPC_NOR  = 17'h00028;
  localparam logic [16:0] OPC_AND  = 17'h00029;
  localparam logic [16:0] OPC_OR   = 17'h0002a;
  localparam logic [16:0] OPC_XOR  = 17'h0002b;
  localparam logic [16:0] OPC_ORN  = 17'h0002c;
  localparam logic [16:0] OPC_ANDN = 17'h0002d;
  localparam logic [16:0] OPC_SLL  = 17'h0002e;
  localparam logic [16:0] OPC_SRL  = 17'h0002f;
  localparam logic [16:0] OPC_SRA  = 17'h00030;

  localparam logic [6:0] OPC_LU12I     = 7'h0a;
  localparam logic [6:0] OPC_PCADDU12I = 7'h0e;

endpackage

// ==== tb/e_exec_checker.sv ====
`timescale 1ns/1ps

module e_exec_checker
  import la_exec_pkg::*;
(
  input logic        clk_i,
  input logic        arst_n_i,
  input logic        inst_valid_i,
  input inst_u       inst_i,
  input logic [31:0] pc_i,
  input logic        wb_valid_i,
  input reg_idx_t    wb_rd_i,
  input logic [31:0] wb_data_i,
  input logic        illegal_i
);

  int unsigned fail_count = 0;
  logic [31:0] shadow [1:31];
  logic        exp_any;    // Something was issued last cycle
  logic        exp_wb;
  logic        exp_ill;
  reg_idx_t    exp_rd;
  logic [31:0] exp_data;
  logic        cur_legal;
  logic [31:0] cur_res;

  // Register value as the DUT sees it, this cycle's writeback included
  function automatic logic [31:0] shadow_read(input reg_idx_t idx);
    if (idx == '0) begin
      return 32'b0;
    end else if (wb_valid_i && wb_rd_i == idx) begin
      return wb_data_i;
    end
    return shadow[idx];
  endfunction

  function automatic logic [31:0] model(input inst_u w, input logic [31:0] pc,
                                        output logic legal);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    a     = shadow_read(w.r3.rj);
    b     = shadow_read(w.r3.rk);
    imm   = {w.ri20.si20, 12'h000};
    legal = 1'b1;
    case (w.r3.opcode)
      OPC_ADD:  res = a + b;
      OPC_SUB:  res = a - b;
      OPC_SLT:  res = {31'b0, (a[31] ^ b[31]) ? a[31] : (a < b)};  // Sign bits differ
      OPC_SLTU: res = {31'b0, a < b};
      OPC_NOR:  res = ~(a | b);
      OPC_AND:  res = a & b;
      OPC_OR:   res = a | b;
      OPC_XOR:  res = a ^ b;
      OPC_ORN:  res = a | ~b;
      OPC_ANDN: res = a & ~b;
      OPC_SLL:  res = a << b[4:0];
      OPC_SRL:  res = a >> b[4:0];
      OPC_SRA:  res = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
      default: begin
        res   = 32'b0;
        legal = 1'b0;
        if (w.ri20.opcode == OPC_LU12I) begin
          res   = imm;
          legal = 1'b1;
        end else if (w.ri20.opcode == OPC_PCADDU12I) begin
          res   = imm + pc;
          legal = 1'b1;
        end
      end
    endcase
    return res;
  endfunction

  always_comb begin
    cur_res = model(inst_i, pc_i, cur_legal);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        shadow[i] <= '0;
      end
      exp_any  <= 1'b0;
      exp_wb   <= 1'b0;
      exp_ill  <= 1'b0;
      exp_rd   <= '0;
      exp_data <= '0;
    end else begin
      if (wb_valid_i && wb_rd_i != '0) begin
        shadow[wb_rd_i] <= wb_data_i;
      end
      exp_any  <= inst_valid_i;
      exp_wb   <= inst_valid_i && cur_legal;
      exp_ill  <= inst_valid_i && !cur_legal;
      exp_rd   <= inst_i.r3.rd;
      exp_data <= cur_res;
    end
  end

  a_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !exp_any |-> !wb_valid_i && !illegal_i)
    else begin
      fail_count = fail_count + 1;
      $error("writeback or illegal pulse without an instruction");
    end

  a_wb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exp_wb |-> wb_valid_i && !illegal_i && wb_rd_i == exp_rd)
    else begin
      fail_count = fail_count + 1;
      $error("missing writeback or wrong rd, expected rd %0d", exp_rd);
    end

  a_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exp_wb |-> wb_data_i == exp_data)
    else begin
      fail_count = fail_count + 1;
      $error("wrong result %08h, expected %08h", wb_data_i, exp_data);
    end

  a_illegal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exp_ill |-> illegal_i && !wb_valid_i)
    else begin
      fail_count = fail_count + 1;
      $error("unknown opcode did not raise illegal alone");
    end

endmodule

bind e_exec_top e_exec_checker u_checker (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .inst_valid_i (inst_valid_i),
  .inst_i       (inst_i),
  .pc_i         (pc_i),
  .wb_valid_i   (wb_valid_o),
  .wb_rd_i      (wb_rd_o),
  .wb_data_i    (wb_data_o),
  .illegal_i    (illegal_o)
);

// ==== tb/tb_e_exec.sv ====
`timescale 1ns/1ps

module tb_e_exec
  import la_exec_pkg::*;
();

  localparam int RESET_CYCLES = 5;
  localparam int RANDOM_COUNT = 300;
  localparam int CYCLE_LIMIT  = 400;  // Reset, ~25 directed, random run, margin

  logic        clk;
  logic        arst_n;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        wb_valid;
  reg_idx_t    wb_rd;
  logic [31:0] wb_data;
  logic        illegal;
  int          seed;
  int          cycles = 0;
  logic [16:0] r3_ops [0:12];

  e_exec_top DUT (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .inst_valid_i (inst_valid),
    .inst_i       (inst),
    .pc_i         (pc),
    .wb_valid_o   (wb_valid),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data),
    .illegal_o    (illegal)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("*** FAILED ***");
      $fatal(1, "timeout: run did not finish");
    end
  end

  // Away from the edge where the assertions fire
  always @(negedge clk) begin
    if (DUT.u_checker.fail_count != 0) begin
      $display("[ERROR] %0t: checker assertion failed", $time);
      $display("*** FAILED ***");
      $fatal(1, "stopped at the first checker failure");
    end
  end

  function automatic logic [31:0] r3_word(input logic [16:0] opc, input reg_idx_t rk,
                                          input reg_idx_t rj, input reg_idx_t rd);
    return {opc, rk, rj, rd};
  endfunction

  function automatic logic [31:0] ri20_word(input logic [6:0] opc, input logic [19:0] si20,
                                            input reg_idx_t rd);
    return {opc, si20, rd};
  endfunction

  task automatic issue(input logic [31:0] word, input logic [31:0] pc_val);
    @(posedge clk);
    #1;
    inst_valid = 1'b1;
    inst       = word;
    pc         = pc_val;
  endtask

  task automatic bubble();
    @(posedge clk);
    #1;
    inst_valid = 1'b0;
  endtask

  task automatic directed_run();
    issue(ri20_word(OPC_LU12I, 20'h80000, 5'd1), 32'h0);
    issue(ri20_word(OPC_LU12I, 20'h00001, 5'd2), 32'h0);
    issue(ri20_word(OPC_LU12I, 20'hfffff, 5'd3), 32'h0);
    issue(ri20_word(OPC_PCADDU12I, 20'h00000, 5'd4), 32'h0000_0025);  // Shift 5, bit 5 set
    issue(ri20_word(OPC_PCADDU12I, 20'h12345, 5'd5), 32'h0000_1004);
    for (int i = 0; i < 13; i++) begin
      issue(r3_word(r3_ops[i], 5'd4, (i % 2 == 1) ? 5'd5 : 5'd1, 5'(i + 6)), 32'h0);
    end
    issue(ri20_word(OPC_LU12I, 20'h54321, 5'd0), 32'h0);
    issue(r3_word(OPC_OR, 5'd0, 5'd0, 5'd20), 32'h0);
    issue(r3_word(OPC_ADD, 5'd3, 5'd2, 5'd21), 32'h0);
    issue(r3_word(OPC_ADD, 5'd21, 5'd21, 5'd21), 32'h0);  // Uses the result just written
    issue(32'hffff_ffff, 32'h0);
    bubble();
    issue(r3_word(OPC_OR, 5'd21, 5'd31, 5'd22), 32'h0);
  endtask

  task automatic random_run();
    logic [31:0] rnd;
    logic [31:0] regs;
    logic [31:0] pc_val;
    logic [3:0]  op_sel;
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      rnd    = $random(seed);
      regs   = $random(seed);
      pc_val = $random(seed);
      op_sel = rnd[7:4] % 4'd13;
      case (rnd[3:0])
        4'd0: bubble();
        4'd1: issue({7'h7f, regs[24:0]}, pc_val);
        4'd2: issue(ri20_word(OPC_LU12I, regs[24:5], regs[4:0]), pc_val);
        4'd3: issue(ri20_word(OPC_PCADDU12I, regs[24:5], regs[4:0]), pc_val);
        default: issue(r3_word(r3_ops[op_sel], regs[14:10], regs[9:5], regs[4:0]), pc_val);
      endcase
    end
  endtask

  initial begin
    seed       = 70211;
    clk        = 1'b0;
    arst_n     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    r3_ops     = '{OPC_ADD, OPC_SUB, OPC_SLT, OPC_SLTU, OPC_NOR, OPC_AND, OPC_OR,
                   OPC_XOR, OPC_ORN, OPC_ANDN, OPC_SLL, OPC_SRL, OPC_SRA};
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    bubble();
    directed_run();
    random_run();
    bubble();
    bubble();
    @(negedge clk);
    if (DUT.u_checker.fail_count != 0) begin
      $display("*** FAILED ***");
      $fatal(1, "checker reported a failure");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule
